// ==== common/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN       = 32;  // Register and PC width
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;  // One word per instruction

  // funct7 patterns of the base ISA
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;  // SUB and SRA/SRAI

  // Major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b000_0011,
    OPC_STORE    = 7'b010_0011,
    OPC_BRANCH   = 7'b110_0011,
    OPC_JALR     = 7'b110_0111,
    OPC_MISC_MEM = 7'b000_1111,
    OPC_JAL      = 7'b110_1111,
    OPC_OP_IMM   = 7'b001_0011,
    OPC_OP       = 7'b011_0011,
    OPC_SYSTEM   = 7'b111_0011,
    OPC_AUIPC    = 7'b001_0111,
    OPC_LUI      = 7'b011_0111
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B  // Operand B straight through, for LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } branch_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LINK  // Return address, pc + 4
  } wb_sel_e;

endpackage

// ==== source/rv_decoder.sv ====
module rv_decoder (
  input  logic [rv_pkg::XLEN-1:0]       insn,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd,
  output logic [rv_pkg::XLEN-1:0]       imm,
  output rv_pkg::alu_op_e               alu_op,
  output logic                          src_a_pc,
  output logic                          src_b_imm,
  output rv_pkg::branch_op_e            branch_op,
  output rv_pkg::wb_sel_e               wb_sel,
  output logic                          stop
);

  rv_pkg::rv_opcode_e     opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_j;

  assign opcode = rv_pkg::rv_opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::ALU_ADD;
    src_a_pc  = 1'b0;
    src_b_imm = 1'b0;
    branch_op = rv_pkg::BR_NONE;
    wb_sel    = rv_pkg::WB_NONE;
    stop      = 1'b0;

    case (opcode)
      rv_pkg::OPC_LUI: begin
        imm       = imm_u;
        alu_op    = rv_pkg::ALU_PASS_B;
        src_b_imm = 1'b1;
        wb_sel    = rv_pkg::WB_ALU;
      end
      rv_pkg::OPC_AUIPC: begin
        imm       = imm_u;
        src_a_pc  = 1'b1;  // pc + upper immediate
        src_b_imm = 1'b1;
        wb_sel    = rv_pkg::WB_ALU;
      end
      rv_pkg::OPC_JAL: begin
        imm       = imm_j;
        branch_op = rv_pkg::BR_JAL;
        wb_sel    = rv_pkg::WB_LINK;
      end
      rv_pkg::OPC_JALR: begin
        imm       = imm_i;
        branch_op = rv_pkg::BR_JALR;
        wb_sel    = rv_pkg::WB_LINK;
        stop      = (funct3 != 3'b000);
      end
      rv_pkg::OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000:  branch_op = rv_pkg::BR_BEQ;
          3'b001:  branch_op = rv_pkg::BR_BNE;
          3'b100:  branch_op = rv_pkg::BR_BLT;
          3'b101:  branch_op = rv_pkg::BR_BGE;
          3'b110:  branch_op = rv_pkg::BR_BLTU;
          3'b111:  branch_op = rv_pkg::BR_BGEU;
          default: stop = 1'b1;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        imm       = imm_i;
        src_b_imm = 1'b1;
        wb_sel    = rv_pkg::WB_ALU;
        case (funct3)
          3'b000: alu_op = rv_pkg::ALU_ADD;
          3'b010: alu_op = rv_pkg::ALU_SLT;
          3'b011: alu_op = rv_pkg::ALU_SLTU;
          3'b100: alu_op = rv_pkg::ALU_XOR;
          3'b110: alu_op = rv_pkg::ALU_OR;
          3'b111: alu_op = rv_pkg::ALU_AND;
          3'b001: begin
            alu_op = rv_pkg::ALU_SLL;
            stop   = (funct7 != rv_pkg::F7_BASE);
          end
          default: begin  // 3'b101 with shamt in imm[4:0]
            alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            stop   = (funct7 != rv_pkg::F7_BASE) && (funct7 != rv_pkg::F7_ALT);
          end
        endcase
      end
      rv_pkg::OPC_OP: begin
        wb_sel = rv_pkg::WB_ALU;
        if (funct7 == rv_pkg::F7_BASE) begin
          case (funct3)
            3'b000: alu_op = rv_pkg::ALU_ADD;
            3'b001: alu_op = rv_pkg::ALU_SLL;
            3'b010: alu_op = rv_pkg::ALU_SLT;
            3'b011: alu_op = rv_pkg::ALU_SLTU;
            3'b100: alu_op = rv_pkg::ALU_XOR;
            3'b101: alu_op = rv_pkg::ALU_SRL;
            3'b110: alu_op = rv_pkg::ALU_OR;
            default: alu_op = rv_pkg::ALU_AND;
          endcase
        end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b000) begin
          alu_op = rv_pkg::ALU_SUB;
        end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b101) begin
          alu_op = rv_pkg::ALU_SRA;
        end else begin
          stop = 1'b1;  // M extension and other funct7 values
        end
      end
      rv_pkg::OPC_MISC_MEM: stop = (funct3 != 3'b000);  // FENCE retires as a no-op
      rv_pkg::OPC_SYSTEM:   stop = 1'b1;  // ECALL and the rest of SYSTEM halt
      rv_pkg::OPC_LOAD,
      rv_pkg::OPC_STORE:    stop = 1'b1;  // No data port
      default:              stop = 1'b1;
    endcase

    // A stopping instruction must not write back or redirect
    if (stop) begin
      wb_sel    = rv_pkg::WB_NONE;
      branch_op = rv_pkg::BR_NONE;
    end
  end

endmodule

// ==== source/rv_regfile.sv ====
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  logic [rv_pkg::XLEN-1:0]       rd_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 never takes a write
      regs[rd] <= rd_data;
    end
  end

  // Combinational reads, x0 holds its reset value
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("regfile: x0 read returned nonzero");

endmodule

// ==== execute/rv_alu.sv ====
module rv_alu (
  input  rv_pkg::alu_op_e         alu_op,
  input  logic                    src_a_pc,
  input  logic                    src_b_imm,
  input  logic [rv_pkg::XLEN-1:0] pc,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] imm,
  output logic [rv_pkg::XLEN-1:0] alu_result
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic                    lt_signed;
  logic                    lt_unsigned;

  assign op_a  = src_a_pc ? pc : rs1_data;  // pc only for AUIPC
  assign op_b  = src_b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLT:    alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_pkg::ALU_SLTU:   alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      // Sign bit fills from the left
      rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

endmodule

// ==== execute/rv_branch_unit.sv ====
module rv_branch_unit (
  input  rv_pkg::branch_op_e      branch_op,
  input  logic [rv_pkg::XLEN-1:0] pc,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] imm,
  output logic                    taken,
  output logic [rv_pkg::XLEN-1:0] target
);

  logic                    eq;
  logic                    lt;
  logic                    ltu;
  logic [rv_pkg::XLEN-1:0] pc_rel;
  logic [rv_pkg::XLEN-1:0] reg_rel;

  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  assign pc_rel  = pc + imm;
  assign reg_rel = rs1_data + imm;

  always_comb begin
    case (branch_op)
      rv_pkg::BR_BEQ:  taken = eq;
      rv_pkg::BR_BNE:  taken = !eq;
      rv_pkg::BR_BLT:  taken = lt;
      rv_pkg::BR_BGE:  taken = !lt;
      rv_pkg::BR_BLTU: taken = ltu;
      rv_pkg::BR_BGEU: taken = !ltu;
      rv_pkg::BR_JAL,
      rv_pkg::BR_JALR: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  // JALR drops bit 0 of the sum
  assign target = (branch_op == rv_pkg::BR_JALR) ? {reg_rel[rv_pkg::XLEN-1:1], 1'b0} : pc_rel;

endmodule

// ==== source/rv_commit.sv ====
module rv_commit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          taken,
  input  logic [rv_pkg::XLEN-1:0]       target,
  input  logic [rv_pkg::XLEN-1:0]       alu_result,
  input  rv_pkg::wb_sel_e               wb_sel,
  input  logic                          stop,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  output logic [rv_pkg::XLEN-1:0]       pc,
  output logic                          halt,
  output logic                          wb_valid,
  output logic [rv_pkg::XLEN-1:0]       wb_data
);

  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] next_pc;

  assign pc_plus4 = pc + rv_pkg::PC_STEP;

  always_comb begin
    if (halt) begin
      next_pc = pc;  // Frozen until reset
    end else if (taken) begin
      next_pc = target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= rv_pkg::RESET_PC;
      halt <= 1'b0;
    end else begin
      pc <= next_pc;
      if (stop) begin
        halt <= 1'b1;  // Sticky
      end
    end
  end

  // Also the register file write enable
  assign wb_valid = (wb_sel != rv_pkg::WB_NONE) && (rd != '0) && !halt;

  always_comb begin
    case (wb_sel)
      rv_pkg::WB_LINK: wb_data = pc_plus4;
      default:         wb_data = alu_result;
    endcase
  end

  pc_word_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00)
    else $error("commit: pc %h not word aligned", pc);

  // A halting instruction never retires a result
  stop_blocks_wb: assert property (@(posedge clk) disable iff (rst)
    stop |-> (wb_sel == rv_pkg::WB_NONE))
    else $error("commit: stop with writeback selected");

endmodule

// ==== source/rv_core.sv ====
module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::XLEN-1:0]       insn,
  output logic [rv_pkg::XLEN-1:0]       pc,
  output logic                          halt,
  output logic                          wb_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data
);

  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::XLEN-1:0]       imm;
  rv_pkg::alu_op_e               alu_op;
  logic                          src_a_pc;
  logic                          src_b_imm;
  rv_pkg::branch_op_e            branch_op;
  rv_pkg::wb_sel_e               wb_sel;
  logic                          stop;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  logic [rv_pkg::XLEN-1:0]       alu_result;
  logic                          taken;
  logic [rv_pkg::XLEN-1:0]       target;

  // rd field doubles as the trace destination
  rv_decoder decoder_i (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (wb_rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .src_a_pc  (src_a_pc),
    .src_b_imm (src_b_imm),
    .branch_op (branch_op),
    .wb_sel    (wb_sel),
    .stop      (stop)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_valid),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu alu_i (
    .alu_op     (alu_op),
    .src_a_pc   (src_a_pc),
    .src_b_imm  (src_b_imm),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_result (alu_result)
  );

  rv_branch_unit branch_i (
    .branch_op (branch_op),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .taken     (taken),
    .target    (target)
  );

  rv_commit commit_i (
    .clk        (clk),
    .rst        (rst),
    .taken      (taken),
    .target     (target),
    .alu_result (alu_result),
    .wb_sel     (wb_sel),
    .stop       (stop),
    .rd         (wb_rd),
    .pc         (pc),
    .halt       (halt),
    .wb_valid   (wb_valid),
    .wb_data    (wb_data)
  );

endmodule

// ==== sim/rv_core_tb.sv ====
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int SETTLE       = 5;  // Sample point after the falling edge
  localparam int IMEM_WORDS   = 64;
  localparam int GOLDEN_DEPTH = 256;
  localparam int POST_HALT    = 2;  // Cycles watched after halt
  localparam string GOLDEN_FILE = "sim/rv_golden.txt";

  // Record kind in bits [71:64] of a golden word
  localparam logic [7:0] REC_START = 8'h01;
  localparam logic [7:0] REC_WORD  = 8'h02;
  localparam logic [7:0] REC_WB    = 8'h03;
  localparam logic [7:0] REC_FINAL = 8'h04;

  logic        clk;
  logic        rst;
  logic [31:0] insn;
  logic [31:0] pc;
  logic        halt;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [71:0] golden [GOLDEN_DEPTH];
  logic [31:0] imem [IMEM_WORDS];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];

  int cycle_count;
  int cycle_limit;
  int test_errors;
  int pass_count;
  int fail_count;

  rv_core rv_core_i (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .pc       (pc),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Opcode zero is illegal while the upper bits follow the address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ {20'b0, addr[6:2]}, 7'h00};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < 32'(IMEM_WORDS * 4)) begin
      return imem[addr[7:2]];
    end
    return fill_word(addr);
  endfunction

  // Instruction memory answers the pc of the current cycle
  initial begin
    insn = fill_word(32'h0);
    forever begin
      @(negedge clk);
      insn <= fetch_word(pc);
    end
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Cycle limit of %0d reached, the core never halted", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic load_test(inout int idx, output int test_num, output logic [31:0] final_pc);
    logic [71:0] rec;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = fill_word(i * 4);
    end
    exp_rd_q.delete();
    exp_data_q.delete();
    test_num = golden[idx][63:32];
    idx++;
    while (idx < GOLDEN_DEPTH && golden[idx][71:64] != REC_FINAL) begin
      rec = golden[idx];
      if (rec[71:64] == REC_WORD) begin
        imem[rec[39:34]] = rec[31:0];  // Word index from the byte address
      end else if (rec[71:64] == REC_WB) begin
        exp_rd_q.push_back(rec[36:32]);
        exp_data_q.push_back(rec[31:0]);
      end
      idx++;
    end
    final_pc = golden[idx][63:32];
    idx++;
  endtask

  task automatic run_test(input int test_num, input logic [31:0] final_pc);
    int          exp_idx;
    test_errors = 0;
    exp_idx = 0;
    @(negedge clk);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    #SETTLE;
    while (!halt) begin
      if (wb_valid) begin
        if (exp_idx < exp_rd_q.size()) begin
          check_value("wb_rd", 32'(wb_rd), 32'(exp_rd_q[exp_idx]));
          check_value("wb_data", wb_data, exp_data_q[exp_idx]);
        end else begin
          note_failure($sformatf("unexpected writeback of %h to x%0d", wb_data, wb_rd));
        end
        exp_idx++;
      end
      @(negedge clk);
      #SETTLE;
    end
    if (exp_idx < exp_rd_q.size()) begin
      note_failure($sformatf("%0d expected writebacks never appeared",
                             exp_rd_q.size() - exp_idx));
    end
    check_value("pc", pc, final_pc);
    repeat (POST_HALT) begin  // Halted core stays quiet
      @(negedge clk);
      #SETTLE;
      check_value("halt", 32'(halt), 32'd1);
      check_value("wb_valid", 32'(wb_valid), 32'd0);
      check_value("pc", pc, final_pc);
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("Test %0d passed", test_num);
    end else begin
      fail_count++;
      $display("Test %0d failed with %0d errors", test_num, test_errors);
    end
  endtask

  initial begin
    int          idx;
    int          limit;
    int          test_num;
    logic [31:0] final_pc;
    rst = 1'b1;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < GOLDEN_DEPTH; i++) begin
      golden[i] = '0;
    end
    $readmemh(GOLDEN_FILE, golden);

    // Reset plus four cycles per program word
    limit = 0;
    for (int i = 0; i < GOLDEN_DEPTH; i++) begin
      if (golden[i][71:64] == REC_START) limit += RESET_CYCLES;
      if (golden[i][71:64] == REC_WORD) limit += 4;
    end
    cycle_limit = limit;

    idx = 0;
    while (idx < GOLDEN_DEPTH && golden[idx][71:64] == REC_START) begin
      load_test(idx, test_num, final_pc);
      run_test(test_num, final_pc);
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      if (pass_count == 0 && fail_count == 0) begin
        $display("No tests were found in %s", GOLDEN_FILE);
      end
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/rv_golden.txt ====
// Each word is kind_field1_field2 in hex
// Kind 01 test start (number), 02 program word (address, insn)
// Kind 03 expected writeback (rd, data), 04 test end (final pc)

01_00000001_00000000  // Register-immediate operations
02_00000000_FFB00093 02_00000004_0030A113 02_00000008_0030B193 02_0000000C_0FF0C213
02_00000010_12306293 02_00000014_7F00F313 02_00000018_00429393 02_0000001C_01C0D413
02_00000020_4010D493 02_00000024_00000073
03_00000001_FFFFFFFB 03_00000002_00000001 03_00000003_00000000 03_00000004_FFFFFF04
03_00000005_00000123 03_00000006_000007F0 03_00000007_00001230 03_00000008_0000000F
03_00000009_FFFFFFFD
04_00000028_00000000

01_00000002_00000000  // Register-register operations
02_00000000_FEC00093 02_00000004_00300113 02_00000008_402081B3 02_0000000C_4021D233
02_00000010_0021D2B3 02_00000014_0020A333 02_00000018_0020B3B3 02_0000001C_00211433
02_00000020_008084B3 02_00000024_0020C533 02_00000028_0021E5B3 02_0000002C_0030F633
02_00000030_00000073
03_00000001_FFFFFFEC 03_00000002_00000003 03_00000003_FFFFFFE9 03_00000004_FFFFFFFD
03_00000005_1FFFFFFD 03_00000006_00000001 03_00000007_00000000 03_00000008_00000018
03_00000009_00000004 03_0000000A_FFFFFFEF 03_0000000B_FFFFFFEB 03_0000000C_FFFFFFE8
04_00000034_00000000

01_00000003_00000000  // x0 writes, FENCE, ECALL halt
02_00000000_00500013 02_00000004_12345037 02_00000008_0AA04093 02_0000000C_00000133
02_00000010_0FF0000F 02_00000014_00000073 02_00000018_00300193
03_00000001_000000AA 03_00000002_00000000
04_00000018_00000000

01_00000004_00000000  // Conditional branches
02_00000000_FFF00093 02_00000004_00100113 02_00000008_00208463 02_0000000C_00100193
02_00000010_00209463 02_00000014_00200193 02_00000018_0020C463 02_0000001C_00300193
02_00000020_0020D463 02_00000024_00400213 02_00000028_0020E463 02_0000002C_00500293
02_00000030_0020F463 02_00000034_00600313 02_00000038_00210463 02_0000003C_00700393
02_00000040_00800413 02_00000044_00000073
03_00000001_FFFFFFFF 03_00000002_00000001 03_00000003_00000001 03_00000004_00000004
03_00000005_00000005 03_00000008_00000008
04_00000048_00000000

01_00000005_00000000  // JAL, JALR, LUI, AUIPC
02_00000000_123450B7 02_00000004_00001117 02_00000008_00C001EF 02_0000000C_00100213
02_00000010_00200213 02_00000014_02100293 02_00000018_00428367 02_0000001C_00700393
02_00000020_00800393 02_00000024_0080006F 02_00000028_00100413 02_0000002C_FFFFF4B7
02_00000030_00000073
03_00000001_12345000 03_00000002_00001004 03_00000003_0000000C 03_00000005_00000021
03_00000006_0000001C 03_00000009_FFFFF000
04_00000034_00000000

01_00000006_00000000  // Illegal word halts
02_00000000_00900093 02_00000004_FFFFFFFF 02_00000008_00100113
03_00000001_00000009
04_00000008_00000000

// ==== sim.f ====
common/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
execute/rv_alu.sv
execute/rv_branch_unit.sv
source/rv_commit.sv
source/rv_core.sv
sim/rv_core_tb.sv

// ==== Makefile ====
# Verilator flow for the RV32I core

VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= rv_core_tb
RTL_TOP   ?= rv_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_TEXT ?= SIMULATION PASSED

RTL_SRCS := $(shell grep -v '^sim/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "Result: pass"; \
	else \
	  echo "Result: fail, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
